/* tcp_session_tap.f */
mpf_pkg.sv
rx_header_parser.sv
session_match_table.sv
payload_forwarder.sv
tap_ctrl_regs.sv
tcp_session_tap.sv
tap_checker.sv
tb_tcp_session_tap.sv

/* tb_tcp_session_tap.sv */
//####################
// tb_tcp_session_tap
// random eth / ipv4 / tcp frames, reference model of the match table
// wishbone register access, payload beat scoreboard
//####################
module tb_tcp_session_tap;

  localparam int NUM_CH   = 4;
  localparam int NUM_RAND = 24;
  localparam int NUM_PKTS = 14 + NUM_RAND;  // directed + random ops, one frame max each
  localparam int TIMEOUT  = NUM_PKTS * 60 + 2000;

  logic clk, rst_n;
  logic rx_vld_i, rx_sop_i, rx_eop_i;
  logic [63:0] rx_data_i;
  logic [2:0]  rx_empty_i;
  logic wb_cyc_i, wb_stb_i, wb_we_i;
  logic [2:0]  wb_adr_i;
  logic [31:0] wb_dat_i, wb_dat_o;
  logic wb_ack_o;
  logic pay_vld_o, pay_sop_o, pay_eop_o;
  logic [63:0] pay_data_o;
  logic [2:0]  pay_offset_o, pay_empty_o;

  // reference model state
  logic [135:0]      m_key [NUM_CH];
  logic [NUM_CH-1:0] m_armed, m_match, m_seqerr;
  logic [135:0]      m_last_key;
  logic [15:0]       m_last_len;
  int                m_pkt, m_tcp, m_fwd;

  logic [7:0]  frame [0:127];  // frame under construction
  int          frame_len;
  logic [63:0] exp_data_q [$];
  logic [7:0]  exp_ctl_q [$];  // sop, eop, offset, empty
  int          exp_cyc_q [$];  // cycle each payload beat is due
  int          mismatches, other_errs, cycles;

  tcp_session_tap #(.NUM_CH(NUM_CH)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //####################
  // timeout and scoreboard
  //####################
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    logic [7:0] c;
    if (rst_n && exp_cyc_q.size() != 0 && exp_cyc_q[0] == cycles) begin
      exp_cyc_q.delete(0);
      c = exp_ctl_q.pop_front();
      check("pay_vld_o", pay_vld_o, 1'b1);  // one cycle behind the input beat
      check("pay_data_o", pay_data_o, exp_data_q.pop_front());
      check("pay_sop_o", pay_sop_o, c[7]);
      check("pay_eop_o", pay_eop_o, c[6]);
      check("pay_offset_o", pay_offset_o, c[5:3]);
      if (c[6]) check("pay_empty_o", pay_empty_o, c[2:0]);  // empty only on eop
    end else if (rst_n && pay_vld_o) begin
      other_errs++;
      $display("payload beat came out while no forwarded beat was expected");
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // drive just after the edge
  endtask

  //####################
  // wishbone access
  //####################
  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do next_cycle(); while (!wb_ack_o);  // ack one cycle after the request
    rdat = wb_dat_o;
    next_cycle();                        // write lands on the ack edge
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic check_regs();
    logic [31:0] rd;
    bus_access(1'b0, mpf_pkg::REG_ARM, 32'h0, rd);
    check("REG_ARM", rd, 32'(m_armed));
    bus_access(1'b0, mpf_pkg::REG_MATCH, 32'h0, rd);
    check("REG_MATCH", rd, 32'(m_match));
    bus_access(1'b0, mpf_pkg::REG_SEQERR, 32'h0, rd);
    check("REG_SEQERR", rd, 32'(m_seqerr));
    bus_access(1'b0, mpf_pkg::REG_PKT_CNT, 32'h0, rd);
    check("REG_PKT_CNT", rd, 32'(m_pkt));
    bus_access(1'b0, mpf_pkg::REG_TCP_CNT, 32'h0, rd);
    check("REG_TCP_CNT", rd, 32'(m_tcp));
    bus_access(1'b0, mpf_pkg::REG_FWD_CNT, 32'h0, rd);
    check("REG_FWD_CNT", rd, 32'(m_fwd));
    if (m_tcp > 0) begin  // undefined before the first tcp header
      bus_access(1'b0, mpf_pkg::REG_LAST_LEN, 32'h0, rd);
      check("REG_LAST_LEN", rd, 32'(m_last_len));
    end
  endtask

  task automatic arm_channel(input int ch);
    logic [31:0] rd;
    bus_access(1'b1, mpf_pkg::REG_ARM, 32'(1) << ch, rd);
    m_key[ch]   = {m_last_key[135:32], m_last_key[31:0] + 32'(m_last_len)};  // next seq
    m_armed[ch] = 1'b1;
  endtask

  task automatic disarm_channel(input int ch);
    logic [31:0] rd;
    bus_access(1'b1, mpf_pkg::REG_DISARM, 32'(1) << ch, rd);
    m_armed[ch] = 1'b0;
  endtask

  task automatic clear_flags(input int ch);
    logic [31:0] rd;
    bus_access(1'b1, mpf_pkg::REG_MATCH, 32'(1) << ch, rd);
    bus_access(1'b1, mpf_pkg::REG_SEQERR, 32'(1) << ch, rd);
    m_match[ch]  = 1'b0;
    m_seqerr[ch] = 1'b0;
  endtask

  //####################
  // frame building and model
  //####################
  function automatic logic [103:0] rand_tuple();
    logic [31:0] sip, dip, ports;
    sip   = $urandom;
    dip   = $urandom;
    ports = $urandom;
    return {sip, dip, 8'd6, ports};
  endfunction

  task automatic fill_frame(input int len);
    frame_len = len;
    for (int i = 0; i < 128; i++) frame[i] = (i < len) ? 8'($urandom) : 8'h00;
  endtask

  task automatic send_frame(input bit fwd, input int pstart);
    int          nb, empty;
    logic [63:0] d;
    logic        sop, eop;
    nb    = (frame_len + 7) / 8;
    empty = nb * 8 - frame_len;
    m_pkt++;
    for (int b = 0; b < nb; b++) begin
      if ($urandom % 8 == 0) begin  // bubble inside the frame
        rx_vld_i = 1'b0;
        rx_sop_i = 1'b0;
        rx_eop_i = 1'b0;
        next_cycle();
      end
      for (int j = 0; j < 8; j++) d[63-8*j -: 8] = frame[8*b+j];  // byte 0 on top
      rx_vld_i   = 1'b1;
      rx_data_i  = d;
      rx_sop_i   = (b == 0);
      rx_eop_i   = (b == nb - 1);
      rx_empty_i = rx_eop_i ? 3'(empty) : 3'd0;
      if (fwd && b >= pstart / 8) begin
        sop = (b == pstart / 8);
        eop = (b == nb - 1);
        exp_data_q.push_back(d);
        exp_ctl_q.push_back({sop, eop, sop ? 3'(pstart % 8) : 3'd0, eop ? 3'(empty) : 3'd0});
        exp_cyc_q.push_back(cycles + 1);  // registered on the next edge
      end
      next_cycle();
    end
    rx_vld_i = 1'b0;
    rx_sop_i = 1'b0;
    rx_eop_i = 1'b0;
    repeat (2 + $urandom % 3) next_cycle();  // counters settle before reads
  endtask

  task automatic send_other();
    fill_frame(20 + $urandom % 60);
    if ($urandom % 2) begin
      frame[12] = 8'h86;  // ipv6 ethertype
      frame[13] = 8'hdd;
    end else begin
      frame[12] = 8'h08;  // ipv4 carrying udp
      frame[13] = 8'h00;
      frame[14] = 8'h45;
      frame[23] = 8'd17;
    end
    send_frame(1'b0, 0);
  endtask

  task automatic send_tcp(input logic [103:0] tup, input logic [31:0] seq);
    int                doff, plen;
    logic [15:0]       ip_len;
    logic [NUM_CH-1:0] hits;
    doff   = 5 + $urandom % 4;
    plen   = 1 + $urandom % 40;
    ip_len = 16'(20 + 4 * doff + plen);
    fill_frame(34 + 4 * doff + plen);
    frame[12] = 8'h08;
    frame[13] = 8'h00;
    frame[14] = 8'h45;  // version 4, ihl 5
    frame[16] = ip_len[15:8];
    frame[17] = ip_len[7:0];
    frame[23] = 8'd6;
    for (int k = 0; k < 4; k++) begin
      frame[26+k] = tup[103-8*k -: 8];  // sip
      frame[30+k] = tup[71-8*k -: 8];   // dip
      frame[34+k] = tup[31-8*k -: 8];   // sport, dport
      frame[38+k] = seq[31-8*k -: 8];
    end
    frame[46] = {4'(doff), frame[46][3:0]};
    // full key hit forwards and disarms, tuple-only hit flags seq error
    hits = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (m_armed[ch] && m_key[ch] == {tup, seq}) hits[ch] = 1'b1;
      else if (m_armed[ch] && m_key[ch][135:32] == tup) m_seqerr[ch] = 1'b1;
    end
    m_match    = m_match | hits;
    m_armed    = m_armed & ~hits;
    m_last_key = {tup, seq};
    m_last_len = 16'(plen);
    m_tcp++;
    if (|hits) m_fwd++;
    send_frame(|hits, 34 + 4 * doff);
  endtask

  task automatic send_match(input int ch);
    send_tcp(m_key[ch][135:32], m_key[ch][31:0]);
  endtask

  task automatic send_seqerr(input int ch);
    send_tcp(m_key[ch][135:32], m_key[ch][31:0] + 32'd1 + 32'($urandom % 1000));
  endtask

  //####################
  // main sequence
  //####################
  initial begin
    void'($urandom(25244));
    {rst_n, rx_vld_i, rx_sop_i, rx_eop_i, rx_data_i, rx_empty_i} = '0;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
    {m_armed, m_match, m_seqerr, m_last_key, m_last_len} = '0;
    {m_pkt, m_tcp, m_fwd, mismatches, other_errs, cycles} = '0;
    for (int ch = 0; ch < NUM_CH; ch++) m_key[ch] = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    check("pay_vld_o", pay_vld_o, 1'b0);
    check("pay_sop_o", pay_sop_o, 1'b0);
    check("pay_eop_o", pay_eop_o, 1'b0);
    check("wb_ack_o", wb_ack_o, 1'b0);
    check_regs();
    repeat (3) send_other();  // count only, no output
    check_regs();
    repeat (3) begin
      send_tcp(rand_tuple(), $urandom);  // unarmed, dropped
      check_regs();
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      send_tcp(rand_tuple(), $urandom);
      arm_channel(ch);
    end
    check_regs();
    send_match(0);
    check_regs();
    send_seqerr(1);  // ch1 stays armed
    check_regs();
    disarm_channel(2);
    send_match(2);   // dropped after disarm
    check_regs();
    clear_flags(0);
    clear_flags(1);
    check_regs();
    send_match(3);
    check_regs();
    for (int i = 0; i < NUM_RAND; i++) begin
      case ($urandom % 7)
        0: send_other();
        1: send_tcp(rand_tuple(), $urandom);
        2: arm_channel($urandom % NUM_CH);
        3: send_match($urandom % NUM_CH);
        4: send_seqerr($urandom % NUM_CH);
        5: disarm_channel($urandom % NUM_CH);
        default: clear_flags($urandom % NUM_CH);
      endcase
      check_regs();
    end
    while (exp_data_q.size() != 0) next_cycle();
    check_regs();
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, other_errs, dut.u_checker.fail_cnt);
    if (mismatches == 0 && other_errs == 0 && dut.u_checker.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* tap_checker.sv */
//####################
// tap_checker
// stream framing and wishbone ack rules
// bound into tcp_session_tap
//####################
module tap_checker (
  input logic       clk,
  input logic       rst_n,
  input logic       pay_vld_i,
  input logic       pay_sop_i,
  input logic [2:0] pay_offset_i,
  input logic       pay_eop_i,
  input logic       wb_ack_i
);

  int unsigned fail_cnt = 0;  // failed assertions so far

  a_sop_vld: assert property (@(posedge clk) disable iff (!rst_n) pay_sop_i |-> pay_vld_i)
    else begin
      fail_cnt++;
      $error("pay_sop_o high without pay_vld_o");
    end
  a_offset_sop: assert property (@(posedge clk) disable iff (!rst_n)
    (pay_offset_i != 3'd0) |-> pay_sop_i)
    else begin
      fail_cnt++;
      $error("nonzero pay_offset_o outside sop");
    end
  a_eop_vld: assert property (@(posedge clk) disable iff (!rst_n) pay_eop_i |-> pay_vld_i)
    else begin
      fail_cnt++;
      $error("pay_eop_o high without pay_vld_o");
    end
  a_ack_once: assert property (@(posedge clk) disable iff (!rst_n) wb_ack_i |=> !wb_ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o held for two cycles");
    end

endmodule

bind tcp_session_tap tap_checker u_checker (
  .clk(clk), .rst_n(rst_n), .pay_vld_i(pay_vld_o), .pay_sop_i(pay_sop_o),
  .pay_offset_i(pay_offset_o), .pay_eop_i(pay_eop_o), .wb_ack_i(wb_ack_o)
);

/* tcp_session_tap.sv */
//####################
// tcp_session_tap top
// header parser, match table, payload forwarder, wishbone regs
//####################
module tcp_session_tap #(
  parameter int NUM_CH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // mac rx stream, no ready
  input  logic                          rx_vld_i,
  input  logic [mpf_pkg::DATA_W-1:0]    rx_data_i,
  input  logic                          rx_sop_i,
  input  logic                          rx_eop_i,
  input  logic [mpf_pkg::EMPTY_W-1:0]   rx_empty_i,
  // wishbone classic
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [mpf_pkg::WB_ADR_W-1:0]  wb_adr_i,
  input  logic [31:0]                   wb_dat_i,
  output logic [31:0]                   wb_dat_o,
  output logic                          wb_ack_o,
  // payload stream
  output logic                          pay_vld_o,
  output logic [mpf_pkg::DATA_W-1:0]    pay_data_o,
  output logic                          pay_sop_o,
  output logic [mpf_pkg::EMPTY_W-1:0]   pay_offset_o,
  output logic                          pay_eop_o,
  output logic [mpf_pkg::EMPTY_W-1:0]   pay_empty_o
);

  logic                      hdr_done, is_tcp_pkt, hit, fwd;
  logic [mpf_pkg::KEY_W-1:0] hdr_key;
  logic [mpf_pkg::LEN_W-1:0] pay_len;
  logic [6:0]                pay_start;
  logic [NUM_CH-1:0]         match_vec, seqerr_vec, armed_vec, arm_vec, disarm_vec;

  rx_header_parser u_parser (
    .clk, .rst_n, .rx_vld_i, .rx_data_i, .rx_sop_i, .rx_eop_i,
    .hdr_done_o(hdr_done), .hdr_key_o(hdr_key), .pay_len_o(pay_len),
    .pay_start_o(pay_start), .is_tcp_o(is_tcp_pkt)
  );

  session_match_table #(.NUM_CH(NUM_CH)) u_table (
    .clk, .rst_n, .hdr_done_i(hdr_done), .hdr_key_i(hdr_key), .pay_len_i(pay_len),
    .arm_i(arm_vec), .disarm_i(disarm_vec), .hit_o(hit), .match_o(match_vec),
    .seqerr_o(seqerr_vec), .armed_o(armed_vec)
  );

  payload_forwarder u_fwd (
    .clk, .rst_n, .rx_vld_i, .rx_data_i, .rx_eop_i, .rx_empty_i,
    .hdr_done_i(hdr_done), .hit_i(hit), .pay_start_i(pay_start),
    .pay_vld_o, .pay_data_o, .pay_sop_o, .pay_offset_o, .pay_eop_o, .pay_empty_o,
    .fwd_o(fwd)
  );

  tap_ctrl_regs #(.NUM_CH(NUM_CH)) u_regs (
    .clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .armed_i(armed_vec), .match_i(match_vec), .seqerr_i(seqerr_vec),
    .sop_i(rx_vld_i & rx_sop_i), .tcp_i(is_tcp_pkt), .fwd_i(fwd),
    .hdr_done_i(hdr_done), .pay_len_i(pay_len),
    .arm_o(arm_vec), .disarm_o(disarm_vec), .wb_dat_o, .wb_ack_o
  );

endmodule

/* tap_ctrl_regs.sv */
//####################
// tap_ctrl_regs
// wishbone classic slave, arm / disarm pulses
// sticky match and seq error flags, counters, last length
//####################
module tap_ctrl_regs #(
  parameter int NUM_CH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [mpf_pkg::WB_ADR_W-1:0]  wb_adr_i,
  input  logic [31:0]                   wb_dat_i,
  input  logic [NUM_CH-1:0]             armed_i,
  input  logic [NUM_CH-1:0]             match_i,
  input  logic [NUM_CH-1:0]             seqerr_i,
  input  logic                          sop_i,
  input  logic                          tcp_i,
  input  logic                          fwd_i,
  input  logic                          hdr_done_i,
  input  logic [mpf_pkg::LEN_W-1:0]     pay_len_i,
  output logic [NUM_CH-1:0]             arm_o,
  output logic [NUM_CH-1:0]             disarm_o,
  output logic [31:0]                   wb_dat_o,
  output logic                          wb_ack_o
);

  if (NUM_CH < 1 || NUM_CH > mpf_pkg::MAX_CH) begin : g_bad_num_ch
    $error("NUM_CH out of range");
  end

  logic                      req;
  logic                      wr_en;
  logic [NUM_CH-1:0]         match_flag_q;
  logic [NUM_CH-1:0]         seqerr_flag_q;
  logic [31:0]               pkt_cnt_q, tcp_cnt_q, fwd_cnt_q;
  logic [mpf_pkg::LEN_W-1:0] last_len_q;
  logic                      tcp_q;
  logic [31:0]               armed_ext, match_ext, seqerr_ext;
  logic [31:0]               rd_data;

  assign req   = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_en = wb_cyc_i && wb_stb_i && wb_ack_o && wb_we_i;  // writes land on ack

  assign arm_o    = (wr_en && wb_adr_i == mpf_pkg::REG_ARM)    ? wb_dat_i[NUM_CH-1:0] : '0;
  assign disarm_o = (wr_en && wb_adr_i == mpf_pkg::REG_DISARM) ? wb_dat_i[NUM_CH-1:0] : '0;

  //####################
  // flags and counters
  //####################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      match_flag_q  <= '0;
      seqerr_flag_q <= '0;
      pkt_cnt_q     <= '0;
      tcp_cnt_q     <= '0;
      fwd_cnt_q     <= '0;
      tcp_q         <= 1'b0;
      wb_ack_o      <= 1'b0;
    end else begin
      wb_ack_o <= req;  // single-cycle ack
      tcp_q    <= tcp_i;
      // set wins over a w1c in the same cycle
      if (wr_en && wb_adr_i == mpf_pkg::REG_MATCH)
        match_flag_q <= (match_flag_q & ~wb_dat_i[NUM_CH-1:0]) | match_i;
      else
        match_flag_q <= match_flag_q | match_i;
      if (wr_en && wb_adr_i == mpf_pkg::REG_SEQERR)
        seqerr_flag_q <= (seqerr_flag_q & ~wb_dat_i[NUM_CH-1:0]) | seqerr_i;
      else
        seqerr_flag_q <= seqerr_flag_q | seqerr_i;
      if (sop_i)          pkt_cnt_q <= pkt_cnt_q + 1'b1;
      if (tcp_i && !tcp_q) tcp_cnt_q <= tcp_cnt_q + 1'b1;  // rising is_tcp
      if (fwd_i)          fwd_cnt_q <= fwd_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_done_i) last_len_q <= pay_len_i;
  end

  //####################
  // read path
  //####################
  always_comb begin
    armed_ext                = '0;
    match_ext                = '0;
    seqerr_ext               = '0;
    armed_ext[NUM_CH-1:0]    = armed_i;
    match_ext[NUM_CH-1:0]    = match_flag_q;
    seqerr_ext[NUM_CH-1:0]   = seqerr_flag_q;
    case (wb_adr_i)
      mpf_pkg::REG_ARM:     rd_data = armed_ext;
      mpf_pkg::REG_MATCH:   rd_data = match_ext;
      mpf_pkg::REG_SEQERR:  rd_data = seqerr_ext;
      mpf_pkg::REG_PKT_CNT: rd_data = pkt_cnt_q;
      mpf_pkg::REG_TCP_CNT: rd_data = tcp_cnt_q;
      mpf_pkg::REG_FWD_CNT: rd_data = fwd_cnt_q;
      mpf_pkg::REG_LAST_LEN: rd_data = {{(32 - mpf_pkg::LEN_W){1'b0}}, last_len_q};
      default:              rd_data = '0;  // disarm reads 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) wb_dat_o <= rd_data;  // valid with ack
  end

endmodule

/* payload_forwarder.sv */
//####################
// payload_forwarder
// per-packet fsm, idle / parse / forward / drop
// matched tcp payload out, one cycle behind the input
//####################
module payload_forwarder (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         rx_vld_i,
  input  logic [mpf_pkg::DATA_W-1:0]   rx_data_i,
  input  logic                         rx_eop_i,
  input  logic [mpf_pkg::EMPTY_W-1:0]  rx_empty_i,
  input  logic                         hdr_done_i,
  input  logic                         hit_i,
  input  logic [6:0]                   pay_start_i,
  output logic                         pay_vld_o,
  output logic [mpf_pkg::DATA_W-1:0]   pay_data_o,
  output logic                         pay_sop_o,
  output logic [mpf_pkg::EMPTY_W-1:0]  pay_offset_o,
  output logic                         pay_eop_o,
  output logic [mpf_pkg::EMPTY_W-1:0]  pay_empty_o,
  output logic                         fwd_o
);

  localparam logic [1:0] IDLE = 2'd0, PARSE = 2'd1, FORWARD = 2'd2, DROP = 2'd3;

  logic [1:0]                 state_q, state_d;
  logic [mpf_pkg::BEAT_W-1:0] beat_q;      // index of the beat on the bus
  logic [mpf_pkg::BEAT_W-1:0] start_beat;
  logic                       started_q;   // payload sop already sent
  logic                       first_beat;
  logic                       emit;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (rx_vld_i && !rx_eop_i) state_d = PARSE;  // first beat is sop
      PARSE: begin
        if (rx_vld_i && rx_eop_i) state_d = IDLE;     // short or non-tcp
        else if (hdr_done_i)      state_d = hit_i ? FORWARD : DROP;
      end
      FORWARD: if (rx_vld_i && rx_eop_i) state_d = IDLE;
      DROP:    if (rx_vld_i && rx_eop_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      beat_q    <= '0;
      started_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (rx_vld_i) beat_q <= rx_eop_i ? '0 : beat_q + 1'b1;
      if (rx_vld_i && rx_eop_i) started_q <= 1'b0;
      else if (first_beat)      started_q <= 1'b1;
    end
  end

  //####################
  // output stage
  //####################
  assign start_beat = {{(mpf_pkg::BEAT_W - 4){1'b0}}, pay_start_i[6:3]};
  assign first_beat = (state_q == FORWARD) && rx_vld_i && !started_q && (beat_q == start_beat);
  assign emit       = (state_q == FORWARD) && rx_vld_i && (started_q || first_beat);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pay_vld_o    <= 1'b0;
      pay_sop_o    <= 1'b0;
      pay_eop_o    <= 1'b0;
      pay_offset_o <= '0;
    end else begin
      pay_vld_o    <= emit;
      pay_sop_o    <= first_beat;
      pay_eop_o    <= emit && rx_eop_i;
      pay_offset_o <= first_beat ? pay_start_i[2:0] : '0;  // leading bytes to skip
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      pay_data_o  <= rx_data_i;   // data untouched
      pay_empty_o <= rx_empty_i;
    end
  end

  assign fwd_o = pay_sop_o;  // one per forwarded packet

endmodule

/* session_match_table.sv */
//####################
// session_match_table
// per-channel armed flag and stored tuple + expected seq
// compare against every parsed header
//####################
module session_match_table #(
  parameter int NUM_CH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       hdr_done_i,
  input  logic [mpf_pkg::KEY_W-1:0]  hdr_key_i,
  input  logic [mpf_pkg::LEN_W-1:0]  pay_len_i,
  input  logic [NUM_CH-1:0]          arm_i,
  input  logic [NUM_CH-1:0]          disarm_i,
  output logic                       hit_o,
  output logic [NUM_CH-1:0]          match_o,
  output logic [NUM_CH-1:0]          seqerr_o,
  output logic [NUM_CH-1:0]          armed_o
);

  localparam int SEQ_W = mpf_pkg::SEQ_W;

  logic [mpf_pkg::KEY_W-1:0] last_key_q;
  logic [mpf_pkg::LEN_W-1:0] last_len_q;
  logic [SEQ_W-1:0]          next_seq;
  logic [mpf_pkg::KEY_W-1:0] arm_key;
  logic [mpf_pkg::KEY_W-1:0] key_q [NUM_CH];
  logic [NUM_CH-1:0]         armed_q;

  // snapshot source for arming
  always_ff @(posedge clk) begin
    if (hdr_done_i) begin
      last_key_q <= hdr_key_i;
      last_len_q <= pay_len_i;
    end
  end

  assign next_seq = last_key_q[SEQ_W-1:0] + {{(SEQ_W - mpf_pkg::LEN_W){1'b0}}, last_len_q};
  assign arm_key  = {last_key_q[SEQ_W +: mpf_pkg::TUPLE_W], next_seq};

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (arm_i[ch]) key_q[ch] <= arm_key;
    end
  end

  //####################
  // compare
  //####################
  always_comb begin
    match_o  = '0;
    seqerr_o = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      match_o[ch]  = hdr_done_i && armed_q[ch] && (key_q[ch] == hdr_key_i);
      seqerr_o[ch] = hdr_done_i && armed_q[ch] &&
                     (key_q[ch][SEQ_W +: mpf_pkg::TUPLE_W] ==
                      hdr_key_i[SEQ_W +: mpf_pkg::TUPLE_W]) &&
                     (key_q[ch][SEQ_W-1:0] != hdr_key_i[SEQ_W-1:0]);  // tuple ok, seq off
    end
  end

  assign hit_o = |match_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      armed_q <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (disarm_i[ch])     armed_q[ch] <= 1'b0;  // disarm beats arm
        else if (arm_i[ch])   armed_q[ch] <= 1'b1;
        else if (match_o[ch]) armed_q[ch] <= 1'b0;  // one-shot
      end
    end
  end

  assign armed_o = armed_q;

endmodule

/* rx_header_parser.sv */
//####################
// rx_header_parser
// eth -> ipv4 -> tcp header walk on the 64-bit rx stream
// five-tuple, seq, payload length and payload start
//####################
module rx_header_parser (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx_vld_i,
  input  logic [mpf_pkg::DATA_W-1:0]  rx_data_i,
  input  logic                        rx_sop_i,
  input  logic                        rx_eop_i,
  output logic                        hdr_done_o,
  output logic [mpf_pkg::KEY_W-1:0]   hdr_key_o,
  output logic [mpf_pkg::LEN_W-1:0]   pay_len_o,
  output logic [6:0]                  pay_start_o,
  output logic                        is_tcp_o
);

  logic [mpf_pkg::BEAT_W-1:0] beat_q;
  logic [mpf_pkg::BEAT_W-1:0] cur_beat;    // index of the beat on the bus now
  logic [mpf_pkg::DATA_W-1:0] data_dly_q;  // previous valid beat
  logic                       ipv4_q;
  logic                       tcp_ok_q;    // ipv4, ihl 5, tcp, header not yet done
  logic                       tcp_hold_q;
  logic [31:0]                sip_q;
  logic [31:0]                dip_q;
  logic [7:0]                 proto_q;
  logic [15:0]                sp_q;
  logic [15:0]                dp_q;
  logic [15:0]                ip_len_q;
  logic [mpf_pkg::SEQ_W-1:0]  seq_q;
  logic [mpf_pkg::SEQ_W-1:0]  seq_cur;
  logic [3:0]                 doff_q;
  logic [3:0]                 doff_cur;

  assign cur_beat = rx_sop_i ? '0 : beat_q;

  //####################
  // beat count and delay line
  //####################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (rx_vld_i) begin
      beat_q <= rx_eop_i ? '0 : cur_beat + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_vld_i) data_dly_q <= rx_data_i;  // for fields split over two beats
  end

  //####################
  // protocol checks
  //####################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ipv4_q     <= 1'b0;
      tcp_ok_q   <= 1'b0;
      tcp_hold_q <= 1'b0;
    end else if (rx_vld_i) begin
      if (cur_beat == mpf_pkg::ETH_BEAT)
        ipv4_q <= (rx_data_i[31:16] == mpf_pkg::ETH_TYPE_IPV4);
      // ihl sits in the previous beat, proto in this one
      if (cur_beat == '0 || hdr_done_o)
        tcp_ok_q <= 1'b0;
      else if (cur_beat == mpf_pkg::IPHDR_BEAT)
        tcp_ok_q <= ipv4_q && (data_dly_q[11:8] == mpf_pkg::IPV4_IHL) &&
                    (rx_data_i[7:0] == mpf_pkg::IP_PROTO_TCP);
      if (rx_eop_i)
        tcp_hold_q <= 1'b0;
      else if (hdr_done_o)
        tcp_hold_q <= 1'b1;
    end
  end

  //####################
  // field capture
  //####################
  always_ff @(posedge clk) begin
    if (rx_vld_i) begin
      if (cur_beat == mpf_pkg::IPHDR_BEAT) begin
        ip_len_q <= rx_data_i[63:48];  // bytes 16..17
        proto_q  <= rx_data_i[7:0];    // byte 23
      end
      if (cur_beat == mpf_pkg::ADDR_BEAT)
        sip_q <= rx_data_i[47:16];     // bytes 26..29
      if (cur_beat == mpf_pkg::PORT_BEAT) begin
        dip_q <= {data_dly_q[15:0], rx_data_i[63:48]};
        sp_q  <= rx_data_i[47:32];
        dp_q  <= rx_data_i[31:16];
      end
      if (hdr_done_o) begin
        seq_q  <= seq_cur;
        doff_q <= doff_cur;
      end
    end
  end

  assign hdr_done_o = rx_vld_i && tcp_ok_q && (cur_beat == mpf_pkg::HDR_DONE_BEAT);

  // live on beat 5, held copy afterwards
  assign seq_cur  = hdr_done_o ? {data_dly_q[15:0], rx_data_i[63:48]} : seq_q;
  assign doff_cur = hdr_done_o ? rx_data_i[15:12] : doff_q;  // byte 46 high nibble

  assign hdr_key_o   = {sip_q, dip_q, proto_q, sp_q, dp_q, seq_cur};
  assign pay_len_o   = ip_len_q - mpf_pkg::IPV4_HDR_BYTES - {10'b0, doff_cur, 2'b00};
  assign pay_start_o = mpf_pkg::TCP_HDR_START + {1'b0, doff_cur, 2'b00};
  assign is_tcp_o    = hdr_done_o | tcp_hold_q;

endmodule

/* mpf_pkg.sv */
//####################
// shared widths for the tcp session tap
// ethernet / ipv4 / tcp constants and header beat positions
// wishbone register map
//####################
package mpf_pkg;

  // stream and key widths
  localparam int DATA_W  = 64;
  localparam int EMPTY_W = 3;
  localparam int TUPLE_W = 104;  // sip, dip, proto, sport, dport
  localparam int SEQ_W   = 32;
  localparam int KEY_W   = TUPLE_W + SEQ_W;
  localparam int LEN_W   = 16;
  localparam int BEAT_W  = 8;
  localparam int MAX_CH  = 32;

  // protocol constants
  localparam logic [15:0]      ETH_TYPE_IPV4  = 16'h0800;
  localparam logic [7:0]       IP_PROTO_TCP   = 8'd6;
  localparam logic [3:0]       IPV4_IHL       = 4'd5;   // no ip options
  localparam logic [LEN_W-1:0] IPV4_HDR_BYTES = 16'd20;
  localparam logic [6:0]       TCP_HDR_START  = 7'd34;  // 14 eth + 20 ip

  // beat index of each header field group, byte 0 in data[63:56]
  localparam logic [BEAT_W-1:0] ETH_BEAT      = 8'd1;  // ethertype, version/ihl
  localparam logic [BEAT_W-1:0] IPHDR_BEAT    = 8'd2;  // total len, proto
  localparam logic [BEAT_W-1:0] ADDR_BEAT     = 8'd3;  // sip
  localparam logic [BEAT_W-1:0] PORT_BEAT     = 8'd4;  // dip low half, ports
  localparam logic [BEAT_W-1:0] HDR_DONE_BEAT = 8'd5;  // seq low half, data offset

  // wishbone word addresses
  localparam int WB_ADR_W = 3;
  localparam logic [WB_ADR_W-1:0] REG_ARM      = 3'd0;
  localparam logic [WB_ADR_W-1:0] REG_DISARM   = 3'd1;
  localparam logic [WB_ADR_W-1:0] REG_MATCH    = 3'd2;
  localparam logic [WB_ADR_W-1:0] REG_SEQERR   = 3'd3;
  localparam logic [WB_ADR_W-1:0] REG_PKT_CNT  = 3'd4;
  localparam logic [WB_ADR_W-1:0] REG_TCP_CNT  = 3'd5;
  localparam logic [WB_ADR_W-1:0] REG_FWD_CNT  = 3'd6;
  localparam logic [WB_ADR_W-1:0] REG_LAST_LEN = 3'd7;

endpackage
